//--- source/fp_alu_pkg.sv
// ==================================================
// Types and constants shared by the FP ALU datapath
// Half operands sit in the low 16 bits of the word
// ==================================================
package fp_alu_pkg;

    localparam int WORD_W        = 32;
    localparam int EXP_W_SINGLE  = 8;
    localparam int EXP_W_HALF    = 5;
    localparam int FRAC_W_SINGLE = 23;
    localparam int FRAC_W_HALF   = 10;
    localparam int MANT_W        = 24;

    localparam int EXP_MAX_SINGLE = 255;
    localparam int EXP_MAX_HALF   = 31;
    localparam int BIAS_SINGLE    = 127;
    localparam int BIAS_HALF      = 15;

    localparam logic [31:0] QNAN_SINGLE = 32'h7FC0_0000;
    localparam logic [15:0] QNAN_HALF   = 16'h7E00;

    typedef enum logic {FMT_HALF = 1'b0, FMT_SINGLE = 1'b1} fp_fmt_e;

    // Code 2'b11 is unused and falls through to the add result
    typedef enum logic [1:0] {OP_ADD = 2'b00, OP_SUB = 2'b01, OP_MUL = 2'b10} fp_op_e;

    typedef enum logic [1:0] {CLS_ZERO, CLS_NORMAL, CLS_INF, CLS_NAN} fp_class_e;

    typedef struct packed {
        logic                     sign;
        logic [EXP_W_SINGLE-1:0]  exp;
        logic [FRAC_W_SINGLE-1:0] frac;
    } fp_single_t;

    typedef struct packed {
        logic [WORD_W-2-EXP_W_HALF-FRAC_W_HALF:0] pad;
        logic                                     sign;
        logic [EXP_W_HALF-1:0]                    exp;
        logic [FRAC_W_HALF-1:0]                   frac;
    } fp_half_t;

    // One operand word, read through the view that fmt selects
    typedef union packed {
        fp_single_t single;
        fp_half_t   half;
    } fp_word_u;

    typedef struct packed {
        fp_class_e               cls;
        logic                    sign;
        logic [EXP_W_SINGLE-1:0] exp;
        logic [MANT_W-1:0]       mant;
        logic                    spare;
    } fp_unpacked_t;

    // Unit result before range checks, exponent is still biased
    typedef struct packed {
        fp_class_e         cls;
        logic              sign;
        logic signed [9:0] exp;
        logic [MANT_W-1:0] mant;
    } fp_raw_t;

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
    } fp_flags_t;

endpackage

//--- source/fp_unpack.sv
// ==================================================
// Operand decode for half or single format
// Denormals are flushed to a zero of the same sign
// ==================================================
`timescale 1ns/1ps

module fp_unpack import fp_alu_pkg::*; (
    input  fp_word_u     word,
    input  fp_fmt_e      fmt,
    output fp_unpacked_t opnd
);

    logic                     sign;
    logic [EXP_W_SINGLE-1:0]  exp;
    logic [FRAC_W_SINGLE-1:0] frac;
    logic [EXP_W_SINGLE-1:0]  exp_max;

    // Widen the selected view to the single layout
    always_comb begin
        if (fmt == FMT_SINGLE) begin
            sign    = word.single.sign;
            exp     = word.single.exp;
            frac    = word.single.frac;
            exp_max = EXP_W_SINGLE'(EXP_MAX_SINGLE);
        end else begin
            sign    = word.half.sign;
            exp     = {{(EXP_W_SINGLE-EXP_W_HALF){1'b0}}, word.half.exp};
            frac    = {word.half.frac, {(FRAC_W_SINGLE-FRAC_W_HALF){1'b0}}};
            exp_max = EXP_W_SINGLE'(EXP_MAX_HALF);
        end
    end

    always_comb begin
        opnd.sign  = sign;
        opnd.exp   = exp;
        opnd.spare = 1'b0;
        if (exp == '0) begin
            // Zero or denormal
            opnd.cls  = CLS_ZERO;
            opnd.mant = '0;
        end else if (exp == exp_max) begin
            opnd.cls  = (frac == '0) ? CLS_INF : CLS_NAN;
            opnd.mant = {1'b0, frac};
        end else begin
            opnd.cls  = CLS_NORMAL;
            opnd.mant = {1'b1, frac};
        end
    end

endmodule

//--- source/fp_add_sub.sv
// ==================================================
// Add or subtract of two unpacked operands
// Alignment shift drops bits, result is truncated
// ==================================================
`timescale 1ns/1ps

module fp_add_sub import fp_alu_pkg::*; (
    input  fp_unpacked_t a,
    input  fp_unpacked_t b,
    input  logic         subtract,
    output fp_raw_t      res
);

    localparam int SUM_W = 2 * MANT_W + 1;

    logic                    b_sign;
    logic                    a_is_big;
    fp_unpacked_t            big;
    fp_unpacked_t            small_op;
    logic                    big_sign;
    logic                    small_sign;
    logic [EXP_W_SINGLE-1:0] exp_diff;
    logic [SUM_W-1:0]        big_ext;
    logic [SUM_W-1:0]        small_ext;
    logic [SUM_W-1:0]        sum;
    logic [SUM_W-1:0]        sum_norm;
    logic [5:0]              lead_zeros;

    assign b_sign   = b.sign ^ subtract;
    assign a_is_big = {a.exp, a.mant} >= {b.exp, b.mant};

    // Larger magnitude goes first so the difference never goes negative
    always_comb begin
        if (a_is_big) begin
            big        = a;
            big_sign   = a.sign;
            small_op   = b;
            small_sign = b_sign;
        end else begin
            big        = b;
            big_sign   = b_sign;
            small_op   = a;
            small_sign = a.sign;
        end
    end

    assign exp_diff  = big.exp - small_op.exp;
    assign big_ext   = {1'b0, big.mant, {MANT_W{1'b0}}};
    assign small_ext = {1'b0, small_op.mant, {MANT_W{1'b0}}} >> exp_diff;
    assign sum       = (big_sign == small_sign) ? big_ext + small_ext
                                                : big_ext - small_ext;

    // Leading one search below the carry bit
    always_comb begin
        lead_zeros = '0;
        for (int i = 0; i < SUM_W - 1; i++) begin
            if (sum[i]) begin
                lead_zeros = 6'(SUM_W - 2 - i);
            end
        end
    end

    assign sum_norm = sum << lead_zeros;

    // ==================================================
    // Special cases, then the normalized sum
    // ==================================================
    always_comb begin
        res.cls  = CLS_NORMAL;
        res.sign = big_sign;
        res.exp  = '0;
        res.mant = '0;
        if (a.cls == CLS_NAN || b.cls == CLS_NAN) begin
            res.cls  = CLS_NAN;
            res.sign = 1'b0;
        end else if (a.cls == CLS_INF && b.cls == CLS_INF && a.sign != b_sign) begin
            res.cls  = CLS_NAN;
            res.sign = 1'b0;
        end else if (a.cls == CLS_INF) begin
            res.cls  = CLS_INF;
            res.sign = a.sign;
        end else if (b.cls == CLS_INF) begin
            res.cls  = CLS_INF;
            res.sign = b_sign;
        end else if (a.cls == CLS_ZERO && b.cls == CLS_ZERO) begin
            res.cls  = CLS_ZERO;
            res.sign = a.sign & b_sign;
        end else if (a.cls == CLS_ZERO) begin
            res.sign = b_sign;
            res.exp  = {2'b00, b.exp};
            res.mant = b.mant;
        end else if (b.cls == CLS_ZERO) begin
            res.sign = a.sign;
            res.exp  = {2'b00, a.exp};
            res.mant = a.mant;
        end else if (sum == '0) begin
            // Exact cancellation
            res.cls  = CLS_ZERO;
            res.sign = 1'b0;
        end else if (sum[SUM_W-1]) begin
            res.exp  = {2'b00, big.exp} + 10'd1;
            res.mant = sum[SUM_W-1:SUM_W-MANT_W];
        end else begin
            res.exp  = {2'b00, big.exp} - {4'b0000, lead_zeros};
            res.mant = sum_norm[SUM_W-2:SUM_W-1-MANT_W];
        end
    end

endmodule

//--- source/fp_mul.sv
// ==================================================
// Multiply of two unpacked operands
// Product is truncated to 24 bits, no rounding
// ==================================================
`timescale 1ns/1ps

module fp_mul import fp_alu_pkg::*; (
    input  fp_unpacked_t a,
    input  fp_unpacked_t b,
    input  fp_fmt_e      fmt,
    output fp_raw_t      res
);

    logic                    prod_sign;
    logic [2*MANT_W-1:0]     product;
    logic signed [9:0]       bias;
    logic signed [9:0]       exp_sum;

    assign prod_sign = a.sign ^ b.sign;
    assign product   = a.mant * b.mant;
    assign bias      = (fmt == FMT_SINGLE) ? 10'(BIAS_SINGLE) : 10'(BIAS_HALF);
    assign exp_sum   = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp}) - bias;

    always_comb begin
        res.cls  = CLS_NORMAL;
        res.sign = prod_sign;
        res.exp  = '0;
        res.mant = '0;
        if (a.cls == CLS_NAN || b.cls == CLS_NAN) begin
            res.cls  = CLS_NAN;
            res.sign = 1'b0;
        end else if ((a.cls == CLS_ZERO && b.cls == CLS_INF) ||
                     (a.cls == CLS_INF && b.cls == CLS_ZERO)) begin
            res.cls  = CLS_NAN;
            res.sign = 1'b0;
        end else if (a.cls == CLS_INF || b.cls == CLS_INF) begin
            res.cls = CLS_INF;
        end else if (a.cls == CLS_ZERO || b.cls == CLS_ZERO) begin
            res.cls = CLS_ZERO;
        end else if (product[2*MANT_W-1]) begin
            // Product in [2, 4)
            res.exp  = exp_sum + 10'sd1;
            res.mant = product[2*MANT_W-1:MANT_W];
        end else begin
            res.exp  = exp_sum;
            res.mant = product[2*MANT_W-2:MANT_W-1];
        end
    end

endmodule

//--- source/fp_pack.sv
// ==================================================
// Range check, flags and result encoding
// Half results leave the upper 16 bits at zero
// ==================================================
`timescale 1ns/1ps

module fp_pack import fp_alu_pkg::*; (
    input  fp_raw_t   raw,
    input  fp_fmt_e   fmt,
    output fp_word_u  word,
    output fp_flags_t flags
);

    logic signed [9:0]        exp_max;
    logic                     sign;
    logic [EXP_W_SINGLE-1:0]  exp_field;
    logic [FRAC_W_SINGLE-1:0] frac_field;

    assign exp_max = (fmt == FMT_SINGLE) ? 10'(EXP_MAX_SINGLE) : 10'(EXP_MAX_HALF);
    assign sign    = raw.sign;

    always_comb begin
        flags      = '0;
        exp_field  = '0;
        frac_field = '0;
        case (raw.cls)
            CLS_NAN: flags.invalid = 1'b1;
            CLS_INF: exp_field = exp_max[EXP_W_SINGLE-1:0];
            CLS_NORMAL: begin
                if (raw.exp >= exp_max) begin
                    exp_field      = exp_max[EXP_W_SINGLE-1:0];
                    flags.overflow = 1'b1;
                end else if (raw.exp <= 0) begin
                    flags.underflow = 1'b1;
                end else begin
                    exp_field  = raw.exp[EXP_W_SINGLE-1:0];
                    frac_field = raw.mant[FRAC_W_SINGLE-1:0];
                end
            end
            default: exp_field = '0;
        endcase
    end

    always_comb begin
        word = '0;
        if (raw.cls == CLS_NAN) begin
            word = (fmt == FMT_SINGLE) ? QNAN_SINGLE : {{(WORD_W-16){1'b0}}, QNAN_HALF};
        end else if (fmt == FMT_SINGLE) begin
            word.single.sign = sign;
            word.single.exp  = exp_field;
            word.single.frac = frac_field;
        end else begin
            word.half.pad  = '0;
            word.half.sign = sign;
            word.half.exp  = exp_field[EXP_W_HALF-1:0];
            word.half.frac = frac_field[FRAC_W_SINGLE-1:FRAC_W_SINGLE-FRAC_W_HALF];
        end
    end

endmodule

//--- source/fp_alu.sv
// ==================================================
// FP ALU top: add, sub, mul in half or single format
// Hold operands from start until valid_out rises
// ==================================================
`timescale 1ns/1ps

module fp_alu import fp_alu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  fp_fmt_e   fmt,
    input  fp_op_e    op_code,
    input  fp_word_u  op_a,
    input  fp_word_u  op_b,
    output fp_word_u  result,
    output fp_flags_t flags,
    output logic      valid_out
);

    typedef enum logic {ST_IDLE, ST_COMPUTE} state_e;

    state_e       state;
    fp_unpacked_t opnd_a;
    fp_unpacked_t opnd_b;
    fp_raw_t      add_sub_raw;
    fp_raw_t      mul_raw;
    fp_raw_t      sel_raw;
    fp_word_u     pack_word;
    fp_flags_t    pack_flags;
    logic         subtract;

    // ==================================================
    // Combinational datapath
    // ==================================================
    fp_unpack u_unpack_a (.word(op_a), .fmt(fmt), .opnd(opnd_a));
    fp_unpack u_unpack_b (.word(op_b), .fmt(fmt), .opnd(opnd_b));

    assign subtract = (op_code == OP_SUB);

    fp_add_sub u_add_sub (.a(opnd_a), .b(opnd_b), .subtract(subtract), .res(add_sub_raw));
    fp_mul     u_mul     (.a(opnd_a), .b(opnd_b), .fmt(fmt), .res(mul_raw));

    always_comb begin
        case (op_code)
            OP_MUL:  sel_raw = mul_raw;
            default: sel_raw = add_sub_raw;
        endcase
    end

    fp_pack u_pack (.raw(sel_raw), .fmt(fmt), .word(pack_word), .flags(pack_flags));

    // ==================================================
    // Idle/compute control and output registers
    // ==================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            valid_out <= 1'b0;
            result    <= '0;
            flags     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    valid_out <= 1'b0;
                    if (start) begin
                        state <= ST_COMPUTE;
                    end
                end
                default: begin
                    // Start is ignored here
                    result    <= pack_word;
                    flags     <= pack_flags;
                    valid_out <= 1'b1;
                    state     <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- verif/fp_alu_asserts.sv
// ==================================================
// Start/valid timing checks, bound into fp_alu
// compute is the control state, high while busy
// ==================================================
`timescale 1ns/1ps

module fp_alu_asserts (
    input logic clk,
    input logic rst,
    input logic start,
    input logic compute,
    input logic valid_out
);

    a_valid_one_cycle: assert property (
        @(posedge clk) disable iff (rst) valid_out |=> !valid_out
    ) else $error("valid_out stayed high for more than one cycle");

    // Start taken while idle gives valid_out two edges later
    a_start_to_valid: assert property (
        @(posedge clk) disable iff (rst) (start && !compute) |=> !valid_out ##1 valid_out
    ) else $error("valid_out did not follow an idle start by two edges");

    a_reset_quiet: assert property (
        @(posedge clk) rst |-> !valid_out
    ) else $error("valid_out high during reset");

endmodule

bind fp_alu fp_alu_asserts fp_alu_asserts_i (
    .clk(clk),
    .rst(rst),
    .start(start),
    .compute(state),
    .valid_out(valid_out)
);

//--- verif/fp_alu_tb.sv
// ==================================================
// Table driven testbench for the FP ALU
// Expected words are hand encoded IEEE-754 values
// ==================================================
`timescale 1ns/1ps

module fp_alu_tb import fp_alu_pkg::*; ();

    localparam int CLK_HALF  = 20;
    localparam int DRIVE_DLY = 2;
    localparam int TIMEOUT   = 10;

    localparam fp_flags_t FLAGS_NONE = 3'b000;
    localparam fp_flags_t FLAGS_INV  = 3'b100;
    localparam fp_flags_t FLAGS_OVF  = 3'b010;
    localparam fp_flags_t FLAGS_UNF  = 3'b001;

    typedef struct packed {
        fp_fmt_e     fmt;
        fp_op_e      op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] exp_result;
        fp_flags_t   exp_flags;
    } row_t;

    logic      clk;
    logic      rst;
    logic      start;
    fp_fmt_e   fmt;
    fp_op_e    op_code;
    fp_word_u  op_a;
    fp_word_u  op_b;
    fp_word_u  result;
    fp_flags_t flags;
    logic      valid_out;

    row_t rows[$];
    int   errors;
    int   checks;

    fp_alu fp_alu_i (
        .clk(clk),
        .rst(rst),
        .start(start),
        .fmt(fmt),
        .op_code(op_code),
        .op_a(op_a),
        .op_b(op_b),
        .result(result),
        .flags(flags),
        .valid_out(valid_out)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic add_row(input fp_fmt_e f, input fp_op_e op, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] exp_result,
                           input fp_flags_t exp_flags);
        row_t r;
        r.fmt        = f;
        r.op         = op;
        r.a          = a;
        r.b          = b;
        r.exp_result = exp_result;
        r.exp_flags  = exp_flags;
        rows.push_back(r);
    endtask

    // ==================================================
    // Stimulus table
    // ==================================================
    task automatic load_table();
        // Normal add and subtract
        add_row(FMT_SINGLE, OP_ADD, 32'h3FC00000, 32'h40100000, 32'h40700000, FLAGS_NONE);
        add_row(FMT_SINGLE, OP_SUB, 32'h40400000, 32'h3F800000, 32'h40000000, FLAGS_NONE);
        add_row(FMT_HALF,   OP_ADD, 32'h00003C00, 32'h00004000, 32'h00004200, FLAGS_NONE);
        add_row(FMT_SINGLE, OP_SUB, 32'h3F800000, 32'h3F800000, 32'h00000000, FLAGS_NONE);
        // Unused op code behaves as add
        add_row(FMT_SINGLE, fp_op_e'(2'b11), 32'h3F800000, 32'h3F800000, 32'h40000000,
                FLAGS_NONE);
        // Multiply, sign is the XOR of the input signs
        add_row(FMT_SINGLE, OP_MUL, 32'h40000000, 32'hC0400000, 32'hC0C00000, FLAGS_NONE);
        add_row(FMT_HALF,   OP_MUL, 32'h00004000, 32'h0000C200, 32'h0000C600, FLAGS_NONE);
        add_row(FMT_SINGLE, OP_MUL, 32'h3FC00001, 32'h40000000, 32'h40400001, FLAGS_NONE);
        // Special operands
        add_row(FMT_SINGLE, OP_ADD, 32'h7F800001, 32'h3F800000, 32'h7FC00000, FLAGS_INV);
        add_row(FMT_HALF,   OP_ADD, 32'h00007C01, 32'h00003C00, 32'h00007E00, FLAGS_INV);
        add_row(FMT_SINGLE, OP_SUB, 32'h7F800000, 32'h7F800000, 32'h7FC00000, FLAGS_INV);
        add_row(FMT_HALF,   OP_SUB, 32'h00007C00, 32'h00007C00, 32'h00007E00, FLAGS_INV);
        add_row(FMT_SINGLE, OP_MUL, 32'h00000000, 32'h7F800000, 32'h7FC00000, FLAGS_INV);
        add_row(FMT_HALF,   OP_MUL, 32'h00000000, 32'h00007C00, 32'h00007E00, FLAGS_INV);
        add_row(FMT_SINGLE, OP_ADD, 32'hFF800000, 32'h3F800000, 32'hFF800000, FLAGS_NONE);
        add_row(FMT_HALF,   OP_ADD, 32'h0000FC00, 32'h00003C00, 32'h0000FC00, FLAGS_NONE);
        add_row(FMT_SINGLE, OP_MUL, 32'h00000001, 32'hC0000000, 32'h80000000, FLAGS_NONE);
        add_row(FMT_HALF,   OP_MUL, 32'h00000001, 32'h0000C000, 32'h00008000, FLAGS_NONE);
        // Range limits
        add_row(FMT_SINGLE, OP_MUL, 32'h7F000000, 32'h40000000, 32'h7F800000, FLAGS_OVF);
        add_row(FMT_HALF,   OP_MUL, 32'h00007800, 32'h00007800, 32'h00007C00, FLAGS_OVF);
        add_row(FMT_SINGLE, OP_MUL, 32'h00800000, 32'h00800000, 32'h00000000, FLAGS_UNF);
    endtask

    // Called one drive delay after the edge that sampled start
    task automatic wait_for_valid(output int edges);
        edges = 1;
        while (!valid_out && edges < TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DLY;
            edges++;
        end
        if (!valid_out) begin
            errors++;
            $display("Timeout: valid_out did not rise within %0d cycles", TIMEOUT);
        end
    endtask

    task automatic run_row(input row_t r);
        int edges;
        fmt     = r.fmt;
        op_code = r.op;
        op_a    = r.a;
        op_b    = r.b;
        start   = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        start = 1'b0;
        wait_for_valid(edges);
        check_value("valid_edges", edges, 2);
        check_value("result", result, r.exp_result);
        check_value("flags", 32'(flags), 32'(r.exp_flags));
        if (r.fmt == FMT_HALF) begin
            check_value("result_upper", result[31:16], 0);
        end
        @(posedge clk);
        #DRIVE_DLY;
        check_value("valid_out_width", valid_out, 0);
    endtask

    // Start stays high through the compute edge and must not restart
    task automatic check_start_ignored();
        int pulses;
        pulses  = 0;
        fmt     = FMT_SINGLE;
        op_code = OP_ADD;
        op_a    = 32'h3F800000;
        op_b    = 32'h40000000;
        start   = 1'b1;
        for (int i = 0; i < 6; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            if (i == 1) begin
                start = 1'b0;
            end
            if (valid_out) begin
                pulses++;
            end
        end
        check_value("valid_pulses", pulses, 1);
        check_value("result", result, 32'h40400000);
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        rst     = 1'b1;
        start   = 1'b0;
        fmt     = FMT_SINGLE;
        op_code = OP_ADD;
        op_a    = '0;
        op_b    = '0;
        load_table();
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        check_value("valid_out", valid_out, 0);
        check_value("result", result, 0);
        check_value("flags", 32'(flags), 0);

        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        check_start_ignored();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- flist.f
source/fp_alu_pkg.sv
source/fp_unpack.sv
source/fp_add_sub.sv
source/fp_mul.sv
source/fp_pack.sv
source/fp_alu.sv
verif/fp_alu_asserts.sv
verif/fp_alu_tb.sv
